// ==== hdl/mem_pkg.sv ====
// memory subsystem package
// shared word, address and byte-enable types, the Wishbone request and
// response structs, the fetch command and beat structs and the fetch FSM states

package mem_pkg;

    // one 32-bit data or instruction word
    typedef logic [31:0] word_t;

    // word address, the RAM only looks at its low bits
    typedef logic [31:0] waddr_t;

    // one enable per byte lane of a word
    typedef logic [3:0] byte_en_t;

    // number of lines in a fetch command, zero means nothing to do
    typedef logic [7:0] line_cnt_t;

    // Wishbone classic request from the host, adr is a byte address
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        byte_en_t sel;
        logic [31:0] adr;
        word_t    dat;
    } wb_req_t;

    // Wishbone classic response back to the host
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    // fetch command, start is a word address
    typedef struct packed {
        waddr_t    start;
        line_cnt_t lines;
    } fetch_cmd_t;

    // one word of the instruction stream with its word address
    typedef struct packed {
        waddr_t addr;
        word_t  data;
    } instr_beat_t;

    // states of the instruction fetch FSM
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_READ,
        FETCH_LOAD,
        FETCH_STREAM
    } fetch_state_t;

endpackage

// ==== hdl/dp_ram.sv ====
// dual-port word RAM
// port A is a read-only line port returning LINE_WORDS consecutive words,
// port B is a 32-bit read/write port with byte enables
// both ports take word addresses and register their read data

`timescale 1ns/1ns

module dp_ram #(
    parameter int ADDR_WIDTH = 10,
    parameter int LINE_WORDS = 4
) (
    input  logic                                clk_i,

    input  logic                                en_a_i,
    input  mem_pkg::waddr_t                     addr_a_i,
    output mem_pkg::word_t [LINE_WORDS-1:0]     rdata_a_o,

    input  logic                                en_b_i,
    input  logic                                we_b_i,
    input  mem_pkg::byte_en_t                   be_b_i,
    input  mem_pkg::waddr_t                     addr_b_i,
    input  mem_pkg::word_t                      wdata_b_i,
    output mem_pkg::word_t                      rdata_b_o
);

    // word index width and depth, the byte offset bits are not stored
    localparam int IDX_W = ADDR_WIDTH - 2;
    localparam int DEPTH = 2 ** IDX_W;

    mem_pkg::word_t mem [DEPTH];

    logic [IDX_W-1:0] idx_a;
    logic [IDX_W-1:0] idx_b;

    // only the low address bits select a word, higher bits alias
    assign idx_a = addr_a_i[IDX_W-1:0];
    assign idx_b = addr_b_i[IDX_W-1:0];

    // line read on port A
    // the index is truncated to IDX_W bits so a line crossing the top wraps to zero
    // nonblocking reads return the old word when port B writes the same word
    always_ff @(posedge clk_i) begin
        if (en_a_i) begin
            for (int i = 0; i < LINE_WORDS; i++) begin
                rdata_a_o[i] <= mem[IDX_W'(idx_a + i)];
            end
        end
    end

    // word port B, writes touch only the enabled byte lanes
    always_ff @(posedge clk_i) begin
        if (en_b_i) begin
            if (we_b_i) begin
                for (int j = 0; j < 4; j++) begin
                    if (be_b_i[j]) begin
                        mem[idx_b][j*8 +: 8] <= wdata_b_i[j*8 +: 8];
                    end
                end
            end else begin
                rdata_b_o <= mem[idx_b];
            end
        end
    end

endmodule

// ==== hdl/wb_data_port.sv ====
// Wishbone classic slave for the RAM data port
// turns single bus cycles into port B accesses, one access per cycle,
// and returns a one-cycle acknowledge with the read data

`timescale 1ns/1ns

module wb_data_port (
    input  logic                clk_i,
    input  logic                reset_i,

    input  mem_pkg::wb_req_t    wb_req_i,
    output mem_pkg::wb_rsp_t    wb_rsp_o,

    output logic                ram_en_o,
    output logic                ram_we_o,
    output mem_pkg::byte_en_t   ram_be_o,
    output mem_pkg::waddr_t     ram_addr_o,
    output mem_pkg::word_t      ram_wdata_o,
    input  mem_pkg::word_t      ram_rdata_i
);

    // bus cycle states
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_READ_WAIT,
        WB_ACK
    } wb_state_t;

    wb_state_t      state_q;
    wb_state_t      state_d;
    logic           req_seen;
    mem_pkg::word_t rdata_q;

    // a new request only counts in idle
    // in the ack cycle the master still holds stb, so it must be ignored there
    assign req_seen = (state_q == WB_IDLE) && wb_req_i.cyc && wb_req_i.stb;

    // the RAM is touched once, on the cycle the request is first seen
    assign ram_en_o    = req_seen;
    assign ram_we_o    = wb_req_i.we;
    assign ram_be_o    = wb_req_i.sel;
    assign ram_wdata_o = wb_req_i.dat;

    // byte address to word address, the only place this conversion is done
    assign ram_addr_o  = {2'b00, wb_req_i.adr[31:2]};

    always_comb begin
        state_d = state_q;
        case (state_q)
            WB_IDLE: begin
                // a write is done on this edge, a read needs one more cycle
                if (req_seen) begin
                    state_d = wb_req_i.we ? WB_ACK : WB_READ_WAIT;
                end
            end
            WB_READ_WAIT: begin
                state_d = WB_ACK;
            end
            WB_ACK: begin
                state_d = WB_IDLE;
            end
            default: begin
                state_d = WB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= WB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the RAM read data is valid in the wait cycle and is held for the ack
    always_ff @(posedge clk_i) begin
        if (state_q == WB_READ_WAIT) begin
            rdata_q <= ram_rdata_i;
        end
    end

    // ack lasts exactly the one cycle spent in the ack state
    assign wb_rsp_o.ack = (state_q == WB_ACK);
    assign wb_rsp_o.dat = rdata_q;

endmodule

// ==== hdl/fetch_ctrl.sv ====
// instruction fetch controller
// accepts fetch commands and, per line, reads the RAM line port, loads the
// serializer and waits until the line has been streamed out

`timescale 1ns/1ns

module fetch_ctrl (
    input  logic    clk_i,
    input  logic    reset_i,

    input  logic    cmd_valid_i,
    output logic    cmd_ready_o,
    input  logic    cmd_lines_zero_i,

    input  logic    last_i,
    input  logic    line_done_i,

    output logic    cnt_load_o,
    output logic    cnt_advance_o,
    output logic    ram_en_o,
    output logic    ser_load_o,
    output logic    busy_o
);

    mem_pkg::fetch_state_t state_q;
    mem_pkg::fetch_state_t state_d;
    logic                  cmd_take;

    // commands are only taken while idle
    assign cmd_ready_o = (state_q == mem_pkg::FETCH_IDLE);
    assign cmd_take    = cmd_ready_o && cmd_valid_i;

    // a zero-line command is consumed but never loads the counter
    assign cnt_load_o  = cmd_take && !cmd_lines_zero_i;

    // the counter address is settled in the read state, RAM data in the load state
    assign ram_en_o    = (state_q == mem_pkg::FETCH_READ);
    assign ser_load_o  = (state_q == mem_pkg::FETCH_LOAD);

    // move to the next line once the current one is fully taken
    assign cnt_advance_o = (state_q == mem_pkg::FETCH_STREAM) && line_done_i && !last_i;

    assign busy_o = (state_q != mem_pkg::FETCH_IDLE);

    always_comb begin
        state_d = state_q;
        case (state_q)
            mem_pkg::FETCH_IDLE: begin
                if (cnt_load_o) begin
                    state_d = mem_pkg::FETCH_READ;
                end
            end
            mem_pkg::FETCH_READ: begin
                state_d = mem_pkg::FETCH_LOAD;
            end
            mem_pkg::FETCH_LOAD: begin
                state_d = mem_pkg::FETCH_STREAM;
            end
            mem_pkg::FETCH_STREAM: begin
                // a stalled stream holds the FSM here, so no line is read ahead
                if (line_done_i) begin
                    state_d = last_i ? mem_pkg::FETCH_IDLE : mem_pkg::FETCH_READ;
                end
            end
            default: begin
                state_d = mem_pkg::FETCH_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= mem_pkg::FETCH_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== hdl/fetch_counter.sv ====
// fetch line counter
// holds the word address of the next line to read and the number of lines
// still to fetch, addresses wrap modulo the RAM depth

`timescale 1ns/1ns

module fetch_counter #(
    parameter int ADDR_WIDTH = 10,
    parameter int LINE_WORDS = 4
) (
    input  logic                clk_i,
    input  logic                reset_i,

    input  logic                load_i,
    input  mem_pkg::fetch_cmd_t cmd_i,
    input  logic                advance_i,

    output mem_pkg::waddr_t     addr_o,
    output logic                last_o
);

    // keeps word addresses inside the RAM so the stream shows the wrap
    localparam mem_pkg::waddr_t WORD_MASK = mem_pkg::waddr_t'((2 ** (ADDR_WIDTH - 2)) - 1);

    mem_pkg::waddr_t    addr_q;
    mem_pkg::line_cnt_t lines_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            addr_q  <= '0;
            lines_q <= '0;
        end else if (load_i) begin
            addr_q  <= cmd_i.start & WORD_MASK;
            lines_q <= cmd_i.lines;
        end else if (advance_i) begin
            addr_q  <= (addr_q + mem_pkg::waddr_t'(LINE_WORDS)) & WORD_MASK;
            lines_q <= lines_q - 1'b1;
        end
    end

    assign addr_o = addr_q;

    // the count includes the line in flight, so one left means final line
    assign last_o = (lines_q == mem_pkg::line_cnt_t'(1));

endmodule

// ==== hdl/line_serializer.sv ====
// line serializer
// captures one RAM line with its base word address and hands the words out
// in order under a valid/ready handshake, each with its own word address

`timescale 1ns/1ns

module line_serializer #(
    parameter int ADDR_WIDTH = 10,
    parameter int LINE_WORDS = 4
) (
    input  logic                                clk_i,
    input  logic                                reset_i,

    input  logic                                load_i,
    input  mem_pkg::waddr_t                     base_i,
    input  mem_pkg::word_t [LINE_WORDS-1:0]     line_i,

    output mem_pkg::instr_beat_t                beat_o,
    output logic                                beat_valid_o,
    input  logic                                beat_ready_i,
    output logic                                line_done_o
);

    // word index inside the line, at least one bit wide
    localparam int IDX_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(LINE_WORDS - 1);
    localparam mem_pkg::waddr_t WORD_MASK = mem_pkg::waddr_t'((2 ** (ADDR_WIDTH - 2)) - 1);

    mem_pkg::word_t [LINE_WORDS-1:0] line_q;
    mem_pkg::waddr_t                 base_q;
    logic [IDX_W-1:0]                idx_q;
    logic                            valid_q;
    logic                            take;

    assign take = valid_q && beat_ready_i;

    // control state, a low ready leaves index and valid untouched
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
            idx_q   <= '0;
        end else if (load_i) begin
            valid_q <= 1'b1;
            idx_q   <= '0;
        end else if (take) begin
            if (idx_q == LAST_IDX) begin
                valid_q <= 1'b0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    // line payload and base address
    always_ff @(posedge clk_i) begin
        if (load_i) begin
            line_q <= line_i;
            base_q <= base_i;
        end
    end

    // beat fields come from registers only, so they stay put while stalled
    assign beat_valid_o = valid_q;
    assign beat_o.data  = line_q[idx_q];
    assign beat_o.addr  = (base_q + mem_pkg::waddr_t'(idx_q)) & WORD_MASK;

    // high only in the cycle the final word of the line is taken
    assign line_done_o  = take && (idx_q == LAST_IDX);

endmodule

// ==== hdl/mem_subsys_top.sv ====
// on-chip memory subsystem top level
// a dual-port RAM with a Wishbone data port on port B and an instruction
// fetch path on the wide port A that streams words out one at a time

`timescale 1ns/1ns

module mem_subsys_top #(
    parameter int ADDR_WIDTH = 10,
    parameter int LINE_WORDS = 4
) (
    input  logic                    clk_i,
    input  logic                    reset_i,

    input  mem_pkg::wb_req_t        wb_req_i,
    output mem_pkg::wb_rsp_t        wb_rsp_o,

    input  mem_pkg::fetch_cmd_t     cmd_i,
    input  logic                    cmd_valid_i,
    output logic                    cmd_ready_o,

    output mem_pkg::instr_beat_t    beat_o,
    output logic                    beat_valid_o,
    input  logic                    beat_ready_i,

    output logic                    busy_o
);

    // port B between the Wishbone slave and the RAM
    logic              ram_en_b;
    logic              ram_we_b;
    mem_pkg::byte_en_t ram_be_b;
    mem_pkg::waddr_t   ram_addr_b;
    mem_pkg::word_t    ram_wdata_b;
    mem_pkg::word_t    ram_rdata_b;

    // fetch path wiring
    logic                            ram_en_a;
    mem_pkg::word_t [LINE_WORDS-1:0] ram_line_a;
    mem_pkg::waddr_t                 line_addr;
    logic                            cnt_load;
    logic                            cnt_advance;
    logic                            cnt_last;
    logic                            ser_load;
    logic                            line_done;
    logic                            cmd_lines_zero;

    assign cmd_lines_zero = (cmd_i.lines == '0);

    dp_ram #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_WORDS (LINE_WORDS)
    ) dp_ram_i (
        .clk_i      (clk_i),
        .en_a_i     (ram_en_a),
        .addr_a_i   (line_addr),
        .rdata_a_o  (ram_line_a),
        .en_b_i     (ram_en_b),
        .we_b_i     (ram_we_b),
        .be_b_i     (ram_be_b),
        .addr_b_i   (ram_addr_b),
        .wdata_b_i  (ram_wdata_b),
        .rdata_b_o  (ram_rdata_b)
    );

    wb_data_port wb_data_port_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .ram_en_o    (ram_en_b),
        .ram_we_o    (ram_we_b),
        .ram_be_o    (ram_be_b),
        .ram_addr_o  (ram_addr_b),
        .ram_wdata_o (ram_wdata_b),
        .ram_rdata_i (ram_rdata_b)
    );

    fetch_ctrl fetch_ctrl_i (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .cmd_valid_i      (cmd_valid_i),
        .cmd_ready_o      (cmd_ready_o),
        .cmd_lines_zero_i (cmd_lines_zero),
        .last_i           (cnt_last),
        .line_done_i      (line_done),
        .cnt_load_o       (cnt_load),
        .cnt_advance_o    (cnt_advance),
        .ram_en_o         (ram_en_a),
        .ser_load_o       (ser_load),
        .busy_o           (busy_o)
    );

    fetch_counter #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_WORDS (LINE_WORDS)
    ) fetch_counter_i (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .load_i     (cnt_load),
        .cmd_i      (cmd_i),
        .advance_i  (cnt_advance),
        .addr_o     (line_addr),
        .last_o     (cnt_last)
    );

    // the base address is still the counter value while the line is loaded
    line_serializer #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_WORDS (LINE_WORDS)
    ) line_serializer_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .load_i       (ser_load),
        .base_i       (line_addr),
        .line_i       (ram_line_a),
        .beat_o       (beat_o),
        .beat_valid_o (beat_valid_o),
        .beat_ready_i (beat_ready_i),
        .line_done_o  (line_done)
    );

endmodule

// ==== testbench/tb_mem_subsys.sv ====
// testbench for the on-chip memory subsystem
// preloads the RAM over Wishbone, checks word and byte-lane accesses and
// checks the instruction fetch stream against a shadow copy of the memory

`timescale 1ns/1ns

module tb_mem_subsys;

    localparam int ADDR_WIDTH = 10;
    localparam int LINE_WORDS = 4;
    localparam int DEPTH      = 2 ** (ADDR_WIDTH - 2);

    // bus operations of the run are the preload, the random word writes and reads,
    // the byte-lane writes and reads and the bus traffic beside the last fetch
    localparam int WB_OPS      = DEPTH + 2 * 16 + 2 * 24 + 2 * 6;
    localparam int FETCH_LINES = 4 + 5 + 3 + 6;
    // a bus access takes at most 4 cycles and a stalled beat is taken as 4 cycles
    localparam int TIMEOUT_CYCLES =
        2 * (WB_OPS * 4 + FETCH_LINES * (LINE_WORDS * 4 + 2)) + 20;

    logic                 clk_i;
    logic                 reset_i;
    mem_pkg::wb_req_t     wb_req_i;
    mem_pkg::wb_rsp_t     wb_rsp_o;
    mem_pkg::fetch_cmd_t  cmd_i;
    logic                 cmd_valid_i;
    logic                 cmd_ready_o;
    mem_pkg::instr_beat_t beat_o;
    logic                 beat_valid_o;
    logic                 beat_ready_i;
    logic                 busy_o;

    // the expected memory contents are kept in step with every bus write
    mem_pkg::word_t       shadow [DEPTH];

    logic [31:0]          rng_state;
    logic [31:0]          ready_state;
    logic                 random_ready;
    int                   errors = 0;
    int                   checks = 0;
    int                   cycle_count = 0;
    int                   wb_age = 0;

    // the fetch in progress as the beat monitor sees it
    mem_pkg::waddr_t      exp_start;
    int                   exp_total = 0;
    int                   beat_count = 0;
    logic                 held_pending = 1'b0;

    mem_subsys_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_WORDS (LINE_WORDS)
    ) mem_subsys_top_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .wb_req_i     (wb_req_i),
        .wb_rsp_o     (wb_rsp_o),
        .cmd_i        (cmd_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .beat_o       (beat_o),
        .beat_valid_o (beat_valid_o),
        .beat_ready_i (beat_ready_i),
        .busy_o       (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next(logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = lcg_next(rng_state);
        return rng_state;
    endfunction

    // a byte-enabled write keeps the disabled lanes of the old word
    function automatic mem_pkg::word_t merge_bytes(mem_pkg::word_t old_w,
                                                   mem_pkg::word_t new_w,
                                                   mem_pkg::byte_en_t be);
        mem_pkg::word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // beat idx of a fetch is the word at start plus idx modulo the depth
    function automatic mem_pkg::instr_beat_t expected_beat(mem_pkg::waddr_t start, int idx);
        mem_pkg::instr_beat_t b;
        mem_pkg::waddr_t      w;
        w      = (start + mem_pkg::waddr_t'(idx)) & mem_pkg::waddr_t'(DEPTH - 1);
        b.addr = w;
        b.data = shadow[w[ADDR_WIDTH-3:0]];
        return b;
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            $display("[FAIL] %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    // one Wishbone classic cycle is held until ack whatever its latency
    task automatic wb_access(input logic we, input mem_pkg::byte_en_t sel,
                             input mem_pkg::waddr_t word_addr, input mem_pkg::word_t wdata,
                             output mem_pkg::word_t rdata);
        @(posedge clk_i);
        wb_req_i.cyc <= 1'b1;
        wb_req_i.stb <= 1'b1;
        wb_req_i.we  <= we;
        wb_req_i.sel <= sel;
        wb_req_i.adr <= {word_addr[29:0], 2'b00};
        wb_req_i.dat <= wdata;
        @(posedge clk_i);
        while (!wb_rsp_o.ack) begin
            @(posedge clk_i);
        end
        rdata = wb_rsp_o.dat;
        wb_req_i.cyc <= 1'b0;
        wb_req_i.stb <= 1'b0;
    endtask

    task automatic wb_write(input mem_pkg::waddr_t word_addr, input mem_pkg::byte_en_t sel,
                            input mem_pkg::word_t wdata);
        mem_pkg::word_t unused;
        wb_access(1'b1, sel, word_addr, wdata, unused);
        shadow[word_addr[ADDR_WIDTH-3:0]] =
            merge_bytes(shadow[word_addr[ADDR_WIDTH-3:0]], wdata, sel);
    endtask

    task automatic wb_read_check(input mem_pkg::waddr_t word_addr);
        mem_pkg::word_t rdata;
        wb_access(1'b0, 4'hf, word_addr, '0, rdata);
        check_value("wb_rsp_o.dat", 64'(rdata), 64'(shadow[word_addr[ADDR_WIDTH-3:0]]));
    endtask

    // issue one fetch command and wait for busy to fall
    task automatic run_fetch(input mem_pkg::waddr_t start, input int lines,
                             input logic rand_ready);
        exp_start  = start;
        exp_total  = lines * LINE_WORDS;
        beat_count = 0;
        random_ready <= rand_ready;
        @(posedge clk_i);
        cmd_i.start <= start;
        cmd_i.lines <= 8'(lines);
        cmd_valid_i <= 1'b1;
        @(posedge clk_i);
        while (!cmd_ready_o) begin
            @(posedge clk_i);
        end
        cmd_valid_i <= 1'b0;
        @(posedge clk_i);
        if (lines == 0) begin
            // a zero-line command must never raise busy
            repeat (4) begin
                check_value("busy_o", 64'(busy_o), 64'(0));
                @(posedge clk_i);
            end
        end else begin
            check_value("busy_o", 64'(busy_o), 64'(1));
            while (busy_o) begin
                @(posedge clk_i);
            end
        end
        check_value("beat count", 64'(beat_count), 64'(exp_total));
        random_ready <= 1'b0;
    endtask

    // the ready pattern has its own generator so bus traffic does not change it
    always @(posedge clk_i) begin
        ready_state = lcg_next(ready_state);
        beat_ready_i <= random_ready ? ready_state[20] : 1'b1;
    end

    // a write is acked one cycle after the request is seen and a read two cycles after
    always @(posedge clk_i) begin
        if (wb_rsp_o.ack) begin
            if (wb_age != (wb_req_i.we ? 1 : 2)) begin
                $display("Wishbone ack came %0d cycles after the request was seen, expected %0d",
                         wb_age, wb_req_i.we ? 1 : 2);
                errors++;
            end
            wb_age <= 0;
        end else if (wb_req_i.cyc && wb_req_i.stb) begin
            wb_age <= wb_age + 1;
        end
    end

    // compares every transferred beat and checks that a stalled beat holds still
    always @(posedge clk_i) begin : beat_monitor
        mem_pkg::instr_beat_t exp_b;
        if (!reset_i) begin
            exp_b = expected_beat(exp_start, beat_count);
            if (held_pending) begin
                // a stalled beat stays valid and keeps showing the next expected word
                check_value("beat_valid_o", 64'(beat_valid_o), 64'(1));
                check_value("beat_o", beat_o, exp_b);
            end
            if (beat_valid_o && beat_ready_i) begin
                if (beat_count >= exp_total) begin
                    $display("a beat was delivered that no fetch command asked for");
                    errors++;
                end else begin
                    check_value("beat_o.addr", 64'(beat_o.addr), 64'(exp_b.addr));
                    check_value("beat_o.data", 64'(beat_o.data), 64'(exp_b.data));
                end
                beat_count++;
            end
            held_pending = beat_valid_o && !beat_ready_i;
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks %0d, errors %0d", checks, errors);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin : main
        logic [31:0]     r;
        mem_pkg::waddr_t a;
        mem_pkg::waddr_t addr_list [16];
        rng_state   = 32'hf47d;
        ready_state = 32'hf47d;
        reset_i      <= 1'b1;
        wb_req_i     <= '0;
        cmd_i        <= '0;
        cmd_valid_i  <= 1'b0;
        beat_ready_i <= 1'b1;
        random_ready <= 1'b0;
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        @(posedge clk_i);
        check_value("wb_rsp_o.ack", 64'(wb_rsp_o.ack), 64'(0));
        check_value("beat_valid_o", 64'(beat_valid_o), 64'(0));
        check_value("busy_o", 64'(busy_o), 64'(0));
        check_value("cmd_ready_o", 64'(cmd_ready_o), 64'(1));

        // preload every word and then do full-word writes at random addresses
        for (int w = 0; w < DEPTH; w++) begin
            wb_write(mem_pkg::waddr_t'(w), 4'hf, rand_word());
        end
        for (int i = 0; i < 16; i++) begin
            r = rand_word();
            addr_list[i] = r & mem_pkg::waddr_t'(DEPTH - 1);
            wb_write(addr_list[i], 4'hf, rand_word());
        end
        for (int i = 0; i < 16; i++) begin
            wb_read_check(addr_list[i]);
        end

        // each byte-lane write is read back at once
        for (int i = 0; i < 24; i++) begin
            r = rand_word();
            a = r & mem_pkg::waddr_t'(DEPTH - 1);
            wb_write(a, r[11:8], rand_word());
            wb_read_check(a);
        end

        run_fetch(32, 4, 1'b0);
        run_fetch(37, 5, 1'b1);
        // crosses the top of memory and wraps to word zero
        run_fetch(mem_pkg::waddr_t'(DEPTH - 6), 3, 1'b1);
        run_fetch(100, 0, 1'b0);

        // bus traffic above the fetched words while the stream runs
        fork
            run_fetch(64, 6, 1'b1);
            begin
                for (int i = 0; i < 6; i++) begin
                    r = rand_word();
                    a = 160 + (r & 32'd63);
                    wb_write(a, r[7:4], rand_word());
                    wb_read_check(a);
                end
            end
        join

        repeat (2) @(posedge clk_i);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
hdl/mem_pkg.sv
hdl/dp_ram.sv
hdl/wb_data_port.sv
hdl/fetch_ctrl.sv
hdl/fetch_counter.sv
hdl/line_serializer.sv
hdl/mem_subsys_top.sv
testbench/tb_mem_subsys.sv

// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat all.f))

.PHONY: run clean

run: obj_dir/Vtb_mem_subsys
	@out="$$(obj_dir/Vtb_mem_subsys)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

obj_dir/Vtb_mem_subsys: all.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_mem_subsys -f all.f

clean:
	rm -rf obj_dir
